//--- design/cpuCore.sv
module cpuCore #(
    parameter mipsPkg::word_t resetPc = 32'hbfc0_0000
) (
    input  logic              clk, rst,
    output mipsPkg::word_t    instAddr,
    input  mipsPkg::word_t    instData,
    output logic              dataEn,
    output logic [3:0]        dataWen,
    output mipsPkg::word_t    dataAddr, dataWdata,
    input  mipsPkg::word_t    dataRdata,
    input  logic              dataStall,
    output mipsPkg::word_t    debugWbPc,
    output logic              debugWbRfWen,
    output mipsPkg::regAddr_t debugWbRfWnum,
    output mipsPkg::word_t    debugWbRfWdata
);
    import mipsPkg::*;

    // fetch / decode
    word_t    pcD, instrD;
    regAddr_t rsD, rtD;
    word_t    rdataA, rdataB;
    // decode / execute
    word_t    pcE, rsValE, rtValE, immE;
    regAddr_t rsE, rtE, rdE;
    aluOp_t   aluOpE;
    memOp_t   memOpE;
    logic     aluImmSelE, regDstE, regWriteEnE, isBranchE, branchNeE;
    logic     branchTaken;
    word_t    branchTarget;
    regAddr_t destE;
    // execute / memory
    word_t    pcM, aluOutM, storeDataM, memFwd;
    regAddr_t destM;
    logic     regWriteEnM;
    memOp_t   memOpM;
    // write-back
    word_t    pcW, resultW;
    regAddr_t destW;
    logic     regWriteEnW;
    logic     wbWen;
    // hazard
    logic     stallF, stallD, flushE, holdAll;
    fwdSel_t  fwdA, fwdB;

    // W holds through a memory stall, so count it only once
    assign wbWen          = regWriteEnW && !dataStall;
    assign debugWbPc      = pcW;
    assign debugWbRfWen   = wbWen;
    assign debugWbRfWnum  = destW;
    assign debugWbRfWdata = resultW;

    fetchStage #(.resetPc(resetPc)) fetch0 (
        .*,
        .stall(stallF),
        .hold (holdAll)
    );

    decodeStage decode0 (
        .*,
        .stall(stallD),
        .flush(flushE)
    );

    regFile regFile0 (
        .clk,
        .raddrA(rsD),
        .raddrB(rtD),
        .waddr (destW),
        .wen   (wbWen),
        .wdata (resultW),
        .rdataA,
        .rdataB
    );

    executeStage execute0 (
        .*,
        .hold (holdAll),
        .wbFwd(resultW)
    );

    memoryStage memory0 (
        .*,
        .hold(holdAll)
    );

    hazardUnit hazard0 (.*);

endmodule

//--- design/decodeStage.sv
module decodeStage (
    input  logic              clk, rst,
    input  logic              stall, flush,
    input  mipsPkg::word_t    pcD, instrD,
    output mipsPkg::regAddr_t rsD, rtD,
    input  mipsPkg::word_t    rdataA, rdataB,
    output mipsPkg::word_t    pcE,
    output mipsPkg::regAddr_t rsE, rtE,
    output mipsPkg::word_t    rsValE, rtValE, immE,
    output mipsPkg::aluOp_t   aluOpE,
    output mipsPkg::memOp_t   memOpE,
    output logic              aluImmSelE, regDstE, regWriteEnE, isBranchE, branchNeE,
    output mipsPkg::regAddr_t rdE
);
    import mipsPkg::*;

    opcode_t  op;
    funct_t   funct;
    regAddr_t rdD;
    word_t    immD;
    aluOp_t   aluOp;
    memOp_t   memOp;
    logic     validFn;
    logic     regDst;
    logic     regWriteEn;
    logic     isBranch;
    logic     zeroExt;

    assign op    = opcode_t'(instrD[31:26]);
    assign funct = funct_t'(instrD[5:0]);
    assign rsD   = instrD[25:21];
    assign rtD   = instrD[20:16];
    assign rdD   = instrD[15:11];

    always_comb begin
        aluOp   = aluAdd;
        memOp   = memNone;
        validFn = 1'b1;
        case (op)
            opAndi: aluOp = aluAnd;
            opOri:  aluOp = aluOr;
            opLui:  aluOp = aluLui;
            opLw:   memOp = memLw;
            opLb:   memOp = memLb;
            opLbu:  memOp = memLbu;
            opSw:   memOp = memSw;
            opSb:   memOp = memSb;
            opSpecial: begin
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: validFn = 1'b0;   // incl. sll $0
                endcase
            end
            default: ;
        endcase
    end

    // unknown opcodes match none of these and fall out as no-ops
    assign regDst     = (op == opSpecial);
    assign isBranch   = op inside {opBeq, opBne};
    assign zeroExt    = op inside {opAndi, opOri, opLui};
    assign regWriteEn = (regDst && validFn)
                      || op inside {opAddiu, opAndi, opOri, opLui, opLw, opLb, opLbu};
    assign immD = zeroExt ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            regWriteEnE <= 1'b0;
            memOpE      <= memNone;
            isBranchE   <= 1'b0;
        end else if (!stall) begin
            regWriteEnE <= regWriteEn;
            memOpE      <= memOp;
            isBranchE   <= isBranch;
        end
        if (!stall) begin
            pcE        <= pcD;
            rsE        <= rsD;
            rtE        <= rtD;
            rdE        <= rdD;
            rsValE     <= rdataA;
            rtValE     <= rdataB;
            immE       <= immD;
            aluOpE     <= aluOp;
            aluImmSelE <= !regDst;
            regDstE    <= regDst;
            branchNeE  <= (op == opBne);
        end
    end

endmodule

//--- design/executeStage.sv
module executeStage (
    input  logic              clk, rst,
    input  logic              hold,
    input  mipsPkg::word_t    pcE,
    input  mipsPkg::regAddr_t rtE,
    input  mipsPkg::word_t    rsValE, rtValE, immE,
    input  mipsPkg::aluOp_t   aluOpE,
    input  mipsPkg::memOp_t   memOpE,
    input  logic              aluImmSelE, regDstE, regWriteEnE, isBranchE, branchNeE,
    input  mipsPkg::regAddr_t rdE,
    input  mipsPkg::fwdSel_t  fwdA, fwdB,
    input  mipsPkg::word_t    memFwd, wbFwd,
    output logic              branchTaken,
    output mipsPkg::word_t    branchTarget,
    output mipsPkg::regAddr_t destE,
    output mipsPkg::word_t    pcM, aluOutM, storeDataM,
    output mipsPkg::regAddr_t destM,
    output logic              regWriteEnM,
    output mipsPkg::memOp_t   memOpM
);
    import mipsPkg::*;

    word_t srcA;
    word_t rtFwd;
    word_t srcB;
    word_t aluOut;

    function automatic word_t pickFwd(fwdSel_t sel, word_t regVal, word_t memVal,
                                      word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA  = pickFwd(fwdA, rsValE, memFwd, wbFwd);
    assign rtFwd = pickFwd(fwdB, rtValE, memFwd, wbFwd);   // also the store data
    assign srcB  = aluImmSelE ? immE : rtFwd;

    always_comb begin
        case (aluOpE)
            aluAdd:  aluOut = srcA + srcB;
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluSlt:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            aluSltu: aluOut = {31'b0, srcA < srcB};
            aluLui:  aluOut = {srcB[15:0], 16'b0};
            default: aluOut = '0;
        endcase
    end

    // offset counts from the delay slot
    assign branchTaken  = isBranchE && ((srcA == rtFwd) != branchNeE);
    assign branchTarget = pcE + 32'd4 + {immE[29:0], 2'b00};
    assign destE        = regDstE ? rdE : rtE;

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteEnM <= 1'b0;
            memOpM      <= memNone;
        end else if (!hold) begin
            regWriteEnM <= regWriteEnE;
            memOpM      <= memOpE;
        end
        if (!hold) begin
            pcM        <= pcE;
            aluOutM    <= aluOut;
            storeDataM <= rtFwd;
            destM      <= destE;
        end
    end

endmodule

//--- design/fetchStage.sv
module fetchStage #(
    parameter mipsPkg::word_t resetPc = 32'hbfc0_0000
) (
    input  logic           clk, rst,
    input  logic           stall, hold,
    input  logic           branchTaken,
    input  mipsPkg::word_t branchTarget,
    output mipsPkg::word_t instAddr,
    input  mipsPkg::word_t instData,
    output mipsPkg::word_t pcD, instrD
);
    import mipsPkg::*;

    word_t pc;
    word_t pcNext;
    logic  advance;

    assign instAddr = pc;
    assign pcNext   = branchTaken ? branchTarget : pc + 32'd4;
    assign advance  = !hold && !stall;   // load-use never coincides with a taken branch

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= resetPc;
            instrD <= '0;
        end else if (advance) begin
            pc     <= pcNext;
            pcD    <= pc;
            // word behind the delay slot turns into sll $0
            instrD <= branchTaken ? '0 : instData;
        end
    end

    // a taken branch leaves no load in execute to stall on
    assert property (@(posedge clk) disable iff (rst) branchTaken |-> !stall);

endmodule

//--- design/hazardUnit.sv
module hazardUnit (
    input  mipsPkg::regAddr_t rsD, rtD, rsE, rtE,
    input  mipsPkg::regAddr_t destE, destM, destW,
    input  logic              regWriteEnE, regWriteEnM, regWriteEnW,
    input  mipsPkg::memOp_t   memOpE, memOpM,
    input  logic              dataStall,
    output logic              stallF, stallD, flushE, holdAll,
    output mipsPkg::fwdSel_t  fwdA, fwdB
);
    import mipsPkg::*;

    logic loadUse;

    function automatic logic isLoad(memOp_t op);
        return op inside {memLw, memLb, memLbu};
    endfunction

    // newest producer wins
    function automatic fwdSel_t pickSrc(regAddr_t src);
        if (src == '0) begin
            return fwdReg;
        end
        if (regWriteEnM && !isLoad(memOpM) && destM == src) begin
            return fwdMem;
        end
        if (regWriteEnW && destW == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign loadUse = regWriteEnE && isLoad(memOpE) && destE != '0
                   && (destE == rsD || destE == rtD);

    assign holdAll = dataStall;
    assign stallF  = loadUse;
    assign stallD  = loadUse || dataStall;
    assign flushE  = loadUse && !dataStall;   // bubble waits until memory lets go

    always_comb begin
        fwdA = pickSrc(rsE);
        fwdB = pickSrc(rtE);
    end

endmodule

//--- design/memoryStage.sv
module memoryStage (
    input  logic              clk, rst,
    input  logic              hold,
    input  mipsPkg::word_t    pcM, aluOutM, storeDataM,
    input  mipsPkg::regAddr_t destM,
    input  logic              regWriteEnM,
    input  mipsPkg::memOp_t   memOpM,
    output logic              dataEn,
    output logic [3:0]        dataWen,
    output mipsPkg::word_t    dataAddr, dataWdata,
    input  mipsPkg::word_t    dataRdata,
    output mipsPkg::word_t    memFwd,
    output mipsPkg::word_t    pcW, resultW,
    output mipsPkg::regAddr_t destW,
    output logic              regWriteEnW
);
    import mipsPkg::*;

    logic [7:0] loadByte;
    word_t      resultM;

    assign dataEn    = (memOpM != memNone);
    assign dataAddr  = aluOutM;
    assign dataWdata = (memOpM == memSb) ? {4{storeDataM[7:0]}} : storeDataM;

    always_comb begin
        case (memOpM)
            memSw:   dataWen = 4'b1111;
            memSb:   dataWen = 4'b0001 << aluOutM[1:0];   // little-endian lanes
            default: dataWen = 4'b0000;
        endcase
    end

    assign loadByte = dataRdata[{aluOutM[1:0], 3'b000} +: 8];

    always_comb begin
        case (memOpM)
            memLw:   resultM = dataRdata;
            memLb:   resultM = {{24{loadByte[7]}}, loadByte};
            memLbu:  resultM = {24'b0, loadByte};
            default: resultM = aluOutM;
        endcase
    end

    // alu result only, load data reaches execute from write-back
    assign memFwd = aluOutM;

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteEnW <= 1'b0;
        end else if (!hold) begin
            regWriteEnW <= regWriteEnM;
        end
        if (!hold) begin
            pcW     <= pcM;
            resultW <= resultM;
            destW   <= destM;
        end
    end

    // word accesses ignore the low address bits
    assert property (@(posedge clk) disable iff (rst)
        memOpM inside {memLw, memSw} |-> aluOutM[1:0] == 2'b00);

endmodule

//--- design/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regCount  = 32;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [$clog2(regCount)-1:0] regAddr_t;

    // primary opcode in instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00, opBeq  = 6'h04, opBne = 6'h05,
        opAddiu   = 6'h09, opAndi = 6'h0c, opOri = 6'h0d, opLui = 6'h0f,
        opLb      = 6'h20, opLw   = 6'h23, opLbu = 6'h24,
        opSb      = 6'h28, opSw   = 6'h2b
    } opcode_t;

    // special-function field in instr[5:0]
    typedef enum logic [5:0] {
        fnAddu = 6'h21, fnSubu = 6'h23, fnAnd  = 6'h24, fnOr = 6'h25,
        fnXor  = 6'h26, fnSlt  = 6'h2a, fnSltu = 6'h2b
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluLui
    } aluOp_t;

    typedef enum logic [2:0] {
        memNone, memLw, memLb, memLbu, memSw, memSb
    } memOp_t;

    // operand source seen by execute
    typedef enum logic [1:0] {
        fwdReg, fwdMem, fwdWb
    } fwdSel_t;

endpackage

//--- design/regFile.sv
module regFile (
    input  logic              clk,
    input  mipsPkg::regAddr_t raddrA, raddrB, waddr,
    input  logic              wen,
    input  mipsPkg::word_t    wdata,
    output mipsPkg::word_t    rdataA, rdataB
);
    import mipsPkg::*;

    word_t regs [regCount];

    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wen && waddr == addr) begin
            return wdata;   // write-back in flight
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdataA = readPort(raddrA);
        rdataB = readPort(raddrB);
    end

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

//--- sim/tbProgram.svh
// each test runs one program, the last one under random dataStall
localparam int testCount = 5;
localparam int progCount = 4;

string testName [testCount] = '{
    "aluForward", "memAccess", "loadUse", "branches", "branchStall"
};
int testProg [testCount] = '{0, 1, 2, 3, 3};
bit testStall [testCount] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

int progLen [progCount] = '{13, 13, 7, 15};
int wbLen   [progCount] = '{13, 10, 6, 9};

// all programs back to back
word_t progWords [48] = '{
    32'h24010005, 32'h24220003, 32'h00221821, 32'h00612023,   // alu chain
    32'h3c058000, 32'h00a1302a, 32'h00a1382b, 32'h34a800ff,
    32'h31090f0f, 32'h01035026, 32'h01245825, 32'h240cffff,
    32'h018a6824,
    32'h24011234, 32'h3c02a5c3, 32'h34421281, 32'hac020100,   // sw / lw
    32'h8c030100, 32'ha0010102, 32'h80040100, 32'h90050100,
    32'h8c060100, 32'h80070102, 32'ha0020107, 32'h80080107,
    32'h8c090104,
    32'h24010077, 32'hac010040, 32'h8c020040, 32'h00411821,   // load then use
    32'h8c040040, 32'h00642823, 32'h00833021,
    32'h24010001, 32'h24020001, 32'h10220003, 32'h24030003,   // beq taken
    32'h24040004, 32'h24050005, 32'h24060006, 32'h14220002,
    32'h24070007, 32'h24080008, 32'h24090009, 32'h15200002,
    32'h240a000a, 32'h240b000b, 32'h240c000c
};

// columns: pc word index, register, value
logic [47:0] wbTable [38] = '{
    {8'd0, 8'd1, 32'h00000005}, {8'd1, 8'd2, 32'h00000008}, {8'd2, 8'd3, 32'h0000000d},
    {8'd3, 8'd4, 32'h00000008}, {8'd4, 8'd5, 32'h80000000}, {8'd5, 8'd6, 32'h00000001},
    {8'd6, 8'd7, 32'h00000000}, {8'd7, 8'd8, 32'h800000ff}, {8'd8, 8'd9, 32'h0000000f},
    {8'd9, 8'd10, 32'h800000f2}, {8'd10, 8'd11, 32'h0000000f},
    {8'd11, 8'd12, 32'hffffffff}, {8'd12, 8'd13, 32'h800000f2},
    {8'd0, 8'd1, 32'h00001234}, {8'd1, 8'd2, 32'ha5c30000}, {8'd2, 8'd2, 32'ha5c31281},
    {8'd4, 8'd3, 32'ha5c31281}, {8'd6, 8'd4, 32'hffffff81}, {8'd7, 8'd5, 32'h00000081},
    {8'd8, 8'd6, 32'ha5341281}, {8'd9, 8'd7, 32'h00000034}, {8'd11, 8'd8, 32'hffffff81},
    {8'd12, 8'd9, 32'h81000000},
    {8'd0, 8'd1, 32'h00000077}, {8'd2, 8'd2, 32'h00000077}, {8'd3, 8'd3, 32'h000000ee},
    {8'd4, 8'd4, 32'h00000077}, {8'd5, 8'd5, 32'h00000077}, {8'd6, 8'd6, 32'h00000165},
    {8'd0, 8'd1, 32'h00000001}, {8'd1, 8'd2, 32'h00000001}, {8'd3, 8'd3, 32'h00000003},
    {8'd6, 8'd6, 32'h00000006}, {8'd8, 8'd7, 32'h00000007}, {8'd9, 8'd8, 32'h00000008},
    {8'd10, 8'd9, 32'h00000009}, {8'd12, 8'd10, 32'h0000000a},
    {8'd14, 8'd12, 32'h0000000c}
};

//--- sim/cpuCoreTb.sv
module cpuCoreTb;
    import mipsPkg::*;

    localparam word_t resetPc = 32'hbfc0_0000;

    logic       clk;
    logic       rst;
    word_t      instAddr, instData;
    logic       dataEn;
    logic [3:0] dataWen;
    word_t      dataAddr, dataWdata, dataRdata;
    logic       dataStall;
    word_t      debugWbPc;
    logic       debugWbRfWen;
    regAddr_t   debugWbRfWnum;
    word_t      debugWbRfWdata;

    `include "tbProgram.svh"

    word_t       imem [256];
    word_t       dmem [256];
    word_t       fetchOffset;
    string       curName;
    int          curErrors;
    int          passCount;
    int          failCount;
    int          cycles = 0;
    int          cycleLimit = 1000;
    logic [31:0] randState;

    cpuCore #(.resetPc(resetPc)) UUT (.*);

    assign fetchOffset = instAddr - resetPc;
    assign instData    = imem[fetchOffset[9:2]];
    assign dataRdata   = dataEn ? dmem[dataAddr[9:2]] : '0;   // combinational read in M

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dataEn && dataWen[i]) begin
                dmem[dataAddr[9:2]][8*i +: 8] <= dataWdata[8*i +: 8];
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles in %s, write-backs stopped coming", cycles,
                     curName);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkResetState();
        if (debugWbRfWen !== 1'b0 || dataEn !== 1'b0 || instAddr !== resetPc) begin
            $display("Error %s: reset expected pc %h wen 0 dataEn 0, got pc %h wen %b dataEn %b",
                     curName, resetPc, instAddr, debugWbRfWen, dataEn);
            curErrors++;
        end
    endtask

    // a partial write must be exactly the lane picked by the low address bits
    task automatic checkLanes();
        if (dataWen != 4'b0000 && dataWen != 4'b1111
            && dataWen != (4'b0001 << dataAddr[1:0])) begin
            $display("Error %s: lanes at %h expected %b, got %b", curName, dataAddr,
                     4'b0001 << dataAddr[1:0], dataWen);
            curErrors++;
        end
    endtask

    task automatic resetCore();
        @(posedge clk);
        #2;
        rst = 1'b1;
        dataStall = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #2;
            if (i == 3) begin
                rst = 1'b0;
            end
            @(negedge clk);
            checkResetState();
        end
    endtask

    task automatic runTest(int t);
        int          prog;
        int          pStart;
        int          eStart;
        int          seen;
        int          idle;
        int          i;
        logic [47:0] expEntry;
        word_t       expPc;
        prog      = testProg[t];
        pStart    = 0;
        eStart    = 0;
        curName   = testName[t];
        curErrors = 0;
        for (i = 0; i < prog; i++) begin
            pStart += progLen[i];
            eStart += wbLen[i];
        end
        for (i = 0; i < 256; i++) begin
            imem[i] = '0;   // sll $0 past the end
            dmem[i] = '0;
        end
        for (i = 0; i < progLen[prog]; i++) begin
            imem[i] = progWords[pStart + i];
        end
        resetCore();
        seen = 0;
        idle = 0;
        while (idle < 8) begin
            @(posedge clk);
            #2;
            randState = xorshift(randState);
            dataStall = testStall[t] && (randState[1:0] == 2'b00);
            @(negedge clk);
            checkLanes();
            if (debugWbRfWen && seen >= wbLen[prog]) begin
                $display("%s: extra write-back of r%0d at pc %h after the last expected one",
                         curName, debugWbRfWnum, debugWbPc);
                curErrors++;
            end else if (debugWbRfWen) begin
                expEntry = wbTable[eStart + seen];
                expPc    = resetPc + {22'b0, expEntry[47:40], 2'b00};
                if (debugWbPc !== expPc || debugWbRfWnum !== expEntry[36:32]
                    || debugWbRfWdata !== expEntry[31:0]) begin
                    $display("Error %s: wb %0d expected pc %h r%0d %h, got pc %h r%0d %h",
                             curName, seen, expPc, expEntry[36:32], expEntry[31:0],
                             debugWbPc, debugWbRfWnum, debugWbRfWdata);
                    curErrors++;
                end
                seen++;
            end
            if (seen >= wbLen[prog]) begin
                idle++;   // watch a while for duplicates
            end
        end
        if (curErrors == 0) begin
            passCount++;
            $display("PASS %s, %0d write-backs", curName, seen);
        end else begin
            failCount++;
            $display("FAIL %s, %0d errors", curName, curErrors);
        end
    endtask

    initial begin
        int t;
        int total;
        rst       = 1'b1;
        dataStall = 1'b0;
        randState = 32'd22994;
        passCount = 0;
        failCount = 0;
        total     = 0;
        for (t = 0; t < testCount; t++) begin
            total += progLen[testProg[t]];
        end
        cycleLimit = 4 * total + 100;
        for (t = 0; t < testCount; t++) begin
            runTest(t);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
design/mipsPkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/hazardUnit.sv
design/cpuCore.sv
sim/cpuCoreTb.sv
